// ==== Makefile ====
# Verilator build and run of the banked SRAM testbench
# Any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= sram_subsystem_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Everything OK
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)

.PHONY: sim clean

# Build, run, and fail unless the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/sram_subsystem_tb.sv ====
/* Directed and random test of the 2048x32 dual-port SRAM. Only words written earlier are
   read back, since the array holds no defined value after power-up */
module sram_subsystem_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import sram_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int LANE_BITS    = DATA_WIDTH / NUM_WMASKS;
    localparam int RAND_CYCLES  = 1200;
    // Bound on the whole run with margin over the cycles the tests take
    localparam int MAX_CYCLES   = 4000;

    logic   soc_clk0;
    logic   arst_n;
    logic   csb0;
    logic   web0;
    wmask_t wmask0;
    addr_t  addr0;
    data_t  din0;
    data_t  dout0;
    logic   csb1;
    addr_t  addr1;
    data_t  dout1;

    // Reference contents of the whole address space
    data_t       ref_mem [2**ADDR_WIDTH];
    logic [31:0] rng_state;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    sram_subsystem UUT (
        .soc_clk0 (soc_clk0),
        .arst_n   (arst_n),
        .csb0     (csb0),
        .web0     (web0),
        .wmask0   (wmask0),
        .addr0    (addr0),
        .din0     (din0),
        .dout0    (dout0),
        .csb1     (csb1),
        .addr1    (addr1),
        .dout1    (dout1)
    );

    initial begin
        soc_clk0 = 1'b0;
        forever #(CLK_PERIOD / 2) soc_clk0 = ~soc_clk0;
    end

    // Run limit
    always @(posedge soc_clk0) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // New word where the mask bit is set, old word elsewhere
    function automatic data_t merge_lanes(input data_t old_word, input data_t new_word,
                                          input wmask_t mask);
        data_t result;
        result = old_word;
        for (int lane = 0; lane < NUM_WMASKS; lane++) begin
            if (mask[lane]) begin
                result[lane*LANE_BITS +: LANE_BITS] = new_word[lane*LANE_BITS +: LANE_BITS];
            end
        end
        return result;
    endfunction

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // Drives both ports for one edge, then checks the reads at the next falling edge
    task automatic run_cycle(
        input logic   c0,
        input logic   w0,
        input wmask_t m0,
        input addr_t  a0,
        input data_t  d0,
        input logic   c1,
        input addr_t  a1
    );
        logic  rd0;
        logic  rd1;
        data_t exp0;
        data_t exp1;
        rd0  = !c0 && w0;
        rd1  = !c1;
        // Reads see the word as it was before a write at the same edge
        exp0 = ref_mem[a0];
        exp1 = ref_mem[a1];
        if (!c0 && !w0) begin
            ref_mem[a0] = merge_lanes(ref_mem[a0], d0, m0);
        end
        csb0   = c0;
        web0   = w0;
        wmask0 = m0;
        addr0  = a0;
        din0   = d0;
        csb1   = c1;
        addr1  = a1;
        @(negedge soc_clk0);
        if (rd0) begin
            check_data("dout0", exp0, dout0);
        end
        if (rd1) begin
            check_data("dout1", exp1, dout1);
        end
    endtask

    task automatic write_word(input addr_t a, input data_t d, input wmask_t m);
        run_cycle(1'b0, 1'b0, m, a, d, 1'b1, '0);
    endtask

    task automatic read_both(input addr_t a0, input addr_t a1);
        run_cycle(1'b0, 1'b1, '0, a0, '0, 1'b0, a1);
    endtask

    // First and last word of every bank
    task automatic bank_mapping_test();
        addr_t a;
        addr_t mirror;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int e = 0; e < 2; e++) begin
                a = addr_t'(b * MACRO_DEPTH + e * (MACRO_DEPTH - 1));
                write_word(a, next_rand(), '1);
            end
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int e = 0; e < 2; e++) begin
                a      = addr_t'(b * MACRO_DEPTH + e * (MACRO_DEPTH - 1));
                mirror = addr_t'((NUM_BANKS - 1 - b) * MACRO_DEPTH + e * (MACRO_DEPTH - 1));
                read_both(a, a);
                read_both(a, mirror);
            end
        end
    endtask

    task automatic byte_mask_test();
        addr_t a;
        for (int m = 1; m < 15; m++) begin
            a = addr_t'(m * 131);
            write_word(a, next_rand(), '1);
            write_word(a, next_rand(), wmask_t'(m));
            read_both(a, a);
        end
    endtask

    task automatic chip_select_test();
        addr_t a;
        data_t d;
        a = addr_t'(777);
        d = next_rand();
        write_word(a, d, '1);
        // Write strobe with csb0 high must leave the word alone
        run_cycle(1'b1, 1'b0, '1, a, ~d, 1'b1, '0);
        read_both(a, a);
    endtask

    task automatic concurrent_port_test();
        addr_t a_lo;
        addr_t a_hi;
        a_lo = addr_t'(40);
        a_hi = addr_t'(1500);
        write_word(a_lo, next_rand(), '1);
        write_word(a_hi, next_rand(), '1);
        read_both(a_lo, a_hi);
        read_both(a_hi, a_lo);
        // Port 1 returns the old word while port 0 writes it
        run_cycle(1'b0, 1'b0, '1, a_hi, next_rand(), 1'b0, a_hi);
        read_both(a_hi, a_hi);
    endtask

    // Spreads 64 indices over the first 16 words of all four banks
    function automatic addr_t window_addr(input logic [5:0] i);
        return addr_t'({i[1:0], 5'b00000, i[5:2]});
    endfunction

    task automatic random_traffic_test();
        logic [31:0] r;
        for (int i = 0; i < 64; i++) begin
            write_word(window_addr(6'(i)), next_rand(), '1);
        end
        for (int n = 0; n < RAND_CYCLES; n++) begin
            r = next_rand();
            run_cycle(r[13:12] == 2'b00, r[14], r[19:16], window_addr(r[5:0]), next_rand(),
                      r[21:20] == 2'b00, window_addr(r[11:6]));
        end
    endtask

    initial begin
        rng_state = 32'h7a9cc7a3;
        arst_n    = 1'b0;
        csb0      = 1'b1;
        web0      = 1'b1;
        wmask0    = '0;
        addr0     = '0;
        din0      = '0;
        csb1      = 1'b1;
        addr1     = '0;
        repeat (RESET_CYCLES) @(posedge soc_clk0);
        @(negedge soc_clk0);
        arst_n = 1'b1;
        @(negedge soc_clk0);

        bank_mapping_test();
        byte_mask_test();
        chip_select_test();
        concurrent_port_test();
        random_traffic_test();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog/sram_macro.sv ====
/* Behavioral model of a 512-word 1RW/1R SRAM macro. Same-edge port 1 reads see the old word,
   and the array contents are undefined after power-up */
module sram_macro (
    input  logic                  soc_clk0,
    input  logic                  arst_n,

    // Read/write port 0
    input  logic                  csb0,
    input  logic                  web0,
    input  sram_pkg::wmask_t      wmask0,
    input  sram_pkg::macro_addr_t addr0,
    input  sram_pkg::data_t       din0,
    output sram_pkg::data_t       dout0,

    // Read-only port 1
    input  logic                  csb1,
    input  sram_pkg::macro_addr_t addr1,
    output sram_pkg::data_t       dout1
);

    import sram_pkg::*;

    // Storage array
    data_t mem [MACRO_DEPTH];

    // Decoded port 0 operation
    logic   wr_en0;
    logic   rd_en0;
    logic   rd_en1;
    wmask_t lane_we;

    // Registered read data
    data_t dout0_q;
    data_t dout1_q;

    assign wr_en0 = !csb0 && !web0;
    assign rd_en0 = !csb0 && web0;
    assign rd_en1 = !csb1;

    // Lane enables only count during a write
    always_comb begin
        lane_we = '0;
        if (wr_en0) begin
            lane_we = wmask0;
        end
    end

    // Byte-masked write
    // Nonblocking update keeps reads at the same edge on the old word
    always_ff @(posedge soc_clk0) begin
        for (int lane = 0; lane < NUM_WMASKS; lane++) begin
            if (lane_we[lane]) begin
                mem[addr0][lane*(DATA_WIDTH/NUM_WMASKS) +: (DATA_WIDTH/NUM_WMASKS)]
                    <= din0[lane*(DATA_WIDTH/NUM_WMASKS) +: (DATA_WIDTH/NUM_WMASKS)];
            end
        end
    end

    // Port 0 read register
    // Holds its value through writes and idle cycles
    always_ff @(posedge soc_clk0 or negedge arst_n) begin
        if (!arst_n) begin
            dout0_q <= '0;
        end else if (rd_en0) begin
            dout0_q <= mem[addr0];
        end
    end

    // Port 1 read register
    always_ff @(posedge soc_clk0 or negedge arst_n) begin
        if (!arst_n) begin
            dout1_q <= '0;
        end else if (rd_en1) begin
            dout1_q <= mem[addr1];
        end
    end

    assign dout0 = dout0_q;
    assign dout1 = dout1_q;

endmodule

// ==== verilog/sram_pkg.sv ====
/* Sizes and types of the banked 2048x32 SRAM. The bank count and macro depth follow from
   the address split, and data words must divide evenly into byte lanes */
package sram_pkg;

    // Byte lanes per word
    localparam int NUM_WMASKS = 4;

    // Word width in bits
    localparam int DATA_WIDTH = 32;

    // Word address as seen by the SoC
    localparam int ADDR_WIDTH = 11;

    // Word address inside one macro
    localparam int MACRO_ADDR_WIDTH = 9;

    // Upper address bits pick the bank
    localparam int BANK_SEL_WIDTH = ADDR_WIDTH - MACRO_ADDR_WIDTH;

    // One macro per bank index
    localparam int NUM_BANKS = 2 ** BANK_SEL_WIDTH;

    // Words held by each macro
    localparam int MACRO_DEPTH = 2 ** MACRO_ADDR_WIDTH;

    // Data word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Per-lane write enables with bit n covering byte n
    typedef logic [NUM_WMASKS-1:0] wmask_t;

    // SoC word address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // In-macro word address
    typedef logic [MACRO_ADDR_WIDTH-1:0] macro_addr_t;

    // Bank index
    typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;

endpackage

// ==== verilog/sram_subsystem.sv ====
/* 2048x32 dual-port SRAM with one read/write and one read-only port. One cycle read latency,
   no arbitration between the ports, so a same-word write and read returns the old word */
module sram_subsystem (
    input  logic             soc_clk0,
    input  logic             arst_n,

    // Read/write port 0
    input  logic             csb0,
    input  logic             web0,
    input  sram_pkg::wmask_t wmask0,
    input  sram_pkg::addr_t  addr0,
    input  sram_pkg::data_t  din0,
    output sram_pkg::data_t  dout0,

    // Read-only port 1
    input  logic             csb1,
    input  sram_pkg::addr_t  addr1,
    output sram_pkg::data_t  dout1
);

    import sram_pkg::*;

    // Wrapper to macro signals with one element per bank
    logic        [NUM_BANKS-1:0] bank_csb0;
    logic        [NUM_BANKS-1:0] bank_web0;
    wmask_t      [NUM_BANKS-1:0] bank_wmask0;
    macro_addr_t [NUM_BANKS-1:0] bank_addr0;
    data_t       [NUM_BANKS-1:0] bank_din0;
    data_t       [NUM_BANKS-1:0] bank_dout0;

    logic        [NUM_BANKS-1:0] bank_csb1;
    macro_addr_t [NUM_BANKS-1:0] bank_addr1;
    data_t       [NUM_BANKS-1:0] bank_dout1;

    // Address decode and read data steering
    sram_wrapper u_wrapper (
        .soc_clk0    (soc_clk0),
        .arst_n      (arst_n),
        .soc_csb0    (csb0),
        .soc_web0    (web0),
        .soc_wmask0  (wmask0),
        .soc_addr0   (addr0),
        .soc_din0    (din0),
        .soc_dout0   (dout0),
        .soc_csb1    (csb1),
        .soc_addr1   (addr1),
        .soc_dout1   (dout1),
        .bank_csb0   (bank_csb0),
        .bank_web0   (bank_web0),
        .bank_wmask0 (bank_wmask0),
        .bank_addr0  (bank_addr0),
        .bank_din0   (bank_din0),
        .bank_dout0  (bank_dout0),
        .bank_csb1   (bank_csb1),
        .bank_addr1  (bank_addr1),
        .bank_dout1  (bank_dout1)
    );

    // Storage banks
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_macro
        sram_macro u_macro (
            .soc_clk0 (soc_clk0),
            .arst_n   (arst_n),
            .csb0     (bank_csb0[b]),
            .web0     (bank_web0[b]),
            .wmask0   (bank_wmask0[b]),
            .addr0    (bank_addr0[b]),
            .din0     (bank_din0[b]),
            .dout0    (bank_dout0[b]),
            .csb1     (bank_csb1[b]),
            .addr1    (bank_addr1[b]),
            .dout1    (bank_dout1[b])
        );
    end

endmodule

// ==== verilog/sram_wrapper.sv ====
/* Splits the SoC word address into bank select and macro address for four banks.
   Returned data is valid only in the cycle right after the read edge */
module sram_wrapper (
    input  logic                                            soc_clk0,
    input  logic                                            arst_n,

    // SoC read/write port 0
    input  logic                                            soc_csb0,
    input  logic                                            soc_web0,
    input  sram_pkg::wmask_t                                soc_wmask0,
    input  sram_pkg::addr_t                                 soc_addr0,
    input  sram_pkg::data_t                                 soc_din0,
    output sram_pkg::data_t                                 soc_dout0,

    // SoC read-only port 1
    input  logic                                            soc_csb1,
    input  sram_pkg::addr_t                                 soc_addr1,
    output sram_pkg::data_t                                 soc_dout1,

    // Macro port 0
    output logic [sram_pkg::NUM_BANKS-1:0]                  bank_csb0,
    output logic [sram_pkg::NUM_BANKS-1:0]                  bank_web0,
    output sram_pkg::wmask_t      [sram_pkg::NUM_BANKS-1:0] bank_wmask0,
    output sram_pkg::macro_addr_t [sram_pkg::NUM_BANKS-1:0] bank_addr0,
    output sram_pkg::data_t       [sram_pkg::NUM_BANKS-1:0] bank_din0,
    input  sram_pkg::data_t       [sram_pkg::NUM_BANKS-1:0] bank_dout0,

    // Macro port 1
    output logic [sram_pkg::NUM_BANKS-1:0]                  bank_csb1,
    output sram_pkg::macro_addr_t [sram_pkg::NUM_BANKS-1:0] bank_addr1,
    input  sram_pkg::data_t       [sram_pkg::NUM_BANKS-1:0] bank_dout1
);

    import sram_pkg::*;

    // Address split
    bank_sel_t   sel0;
    bank_sel_t   sel1;
    macro_addr_t maddr0;
    macro_addr_t maddr1;

    assign sel0   = soc_addr0[ADDR_WIDTH-1:MACRO_ADDR_WIDTH];
    assign sel1   = soc_addr1[ADDR_WIDTH-1:MACRO_ADDR_WIDTH];
    assign maddr0 = soc_addr0[MACRO_ADDR_WIDTH-1:0];
    assign maddr1 = soc_addr1[MACRO_ADDR_WIDTH-1:0];

    // Bank index of the previous edge for the data return
    bank_sel_t sel0_q;
    bank_sel_t sel1_q;

    // Sampled every edge regardless of chip select
    always_ff @(posedge soc_clk0 or negedge arst_n) begin
        if (!arst_n) begin
            sel0_q <= '0;
            sel1_q <= '0;
        end else begin
            sel0_q <= sel0;
            sel1_q <= sel1;
        end
    end

    // Per-bank fan-out
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        // Only the addressed bank sees an active strobe
        assign bank_csb0[b]   = soc_csb0 || (sel0 != bank_sel_t'(b));
        assign bank_web0[b]   = soc_web0;
        assign bank_wmask0[b] = soc_wmask0;
        assign bank_addr0[b]  = maddr0;
        assign bank_din0[b]   = soc_din0;

        assign bank_csb1[b]   = soc_csb1 || (sel1 != bank_sel_t'(b));
        assign bank_addr1[b]  = maddr1;
    end

    // Read data return from the bank accessed one cycle earlier
    assign soc_dout0 = bank_dout0[sel0_q];
    assign soc_dout1 = bank_dout1[sel1_q];

endmodule

// ==== vlog.f ====
verilog/sram_pkg.sv
verilog/sram_macro.sv
verilog/sram_wrapper.sv
verilog/sram_subsystem.sv
bench/sram_subsystem_tb.sv
